//--- common/char_lcd_pkg.sv
// Character LCD controller shared definitions
// Bus timing, display options, request structs and the read-back word
package char_lcd_pkg;

	// LCD bus cycle timing in clk cycles, scaled down for simulation
	localparam int LCD_T_SETUP = 4;
	localparam int LCD_T_EN = 12;
	localparam int LCD_T_HOLD = 4;

	// Panel power-up wait before the first init command
	localparam int LCD_T_POWERUP = 200;

	// Display control options
	localparam logic LCD_CURSOR_ON = 1'b1;
	localparam logic LCD_BLINK_ON = 1'b0;

	// Length of the fixed init command list
	localparam int LCD_INIT_STEPS = 4;

	// Counter widths, enable is the longest bus phase
	localparam int LCD_PHASE_W = $clog2(LCD_T_EN);
	localparam int LCD_PWR_W = $clog2(LCD_T_POWERUP);
	localparam int LCD_STEP_W = $clog2(LCD_INIT_STEPS);

	// Host slave request, held stable while waitrequest is high
	typedef struct packed {
		logic address;
		logic read;
		logic write;
		logic [7:0] writedata;
	} lcd_av_req_t;

	// One panel bus transfer
	typedef struct packed {
		logic rs;
		logic rw;
		logic [7:0] data;
	} lcd_bus_req_t;

	// Status byte layout as returned with rs low
	typedef struct packed {
		logic busy;
		logic [6:0] addr_cnt;
	} lcd_status_t;

	// Byte read back from the panel
	// rs low gives status, rs high gives the DDRAM character
	typedef union packed {
		lcd_status_t status;
		logic [7:0] data;
	} lcd_rd_word_u;

endpackage

//--- char_lcd_bus/char_lcd_bus_xfer.sv
// LCD bus transfer engine
// One 8-bit bus cycle with setup, enable pulse and hold, read capture
`timescale 1ns/1ps

module char_lcd_bus_xfer (
	input logic clk,
	input logic reset,
	input logic start,
	input char_lcd_pkg::lcd_bus_req_t bus_req,
	output logic done,
	output logic [7:0] rdata,
	inout wire [7:0] lcd_data,
	output logic lcd_en,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic lcd_on,
	output logic lcd_blon
);

	import char_lcd_pkg::*;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SETUP,
		PH_EN,
		PH_HOLD,
		PH_DONE
	} phase_t;

	phase_t phase;
	logic [LCD_PHASE_W-1:0] cnt;
	lcd_bus_req_t req_q;
	logic [7:0] rdata_q;
	logic pwr_q;

	// Phase sequencer, requests accepted only when idle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= PH_IDLE;
			cnt <= '0;
			// Bus released, panel not driving
			req_q <= '{rs: 1'b0, rw: 1'b1, data: 8'h00};
		end
		else
		begin
			case (phase)
				PH_IDLE:
				begin
					if (start)
					begin
						req_q <= bus_req;
						cnt <= '0;
						phase <= PH_SETUP;
					end
				end
				PH_SETUP:
				begin
					if (cnt == LCD_PHASE_W'(LCD_T_SETUP - 1))
					begin
						cnt <= '0;
						phase <= PH_EN;
					end
					else
						cnt <= cnt + 1'b1;
				end
				PH_EN:
				begin
					if (cnt == LCD_PHASE_W'(LCD_T_EN - 1))
					begin
						cnt <= '0;
						phase <= PH_HOLD;
					end
					else
						cnt <= cnt + 1'b1;
				end
				PH_HOLD:
				begin
					if (cnt == LCD_PHASE_W'(LCD_T_HOLD - 1))
					begin
						cnt <= '0;
						phase <= PH_DONE;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default:
					phase <= PH_IDLE;
			endcase
		end
	end

	// Read data sampled on the last enable cycle
	always_ff @(posedge clk)
	begin
		if (phase == PH_EN && cnt == LCD_PHASE_W'(LCD_T_EN - 1) && req_q.rw)
			rdata_q <= lcd_data;
	end

	// Panel power and backlight come up once reset is released
	always_ff @(posedge clk)
	begin
		if (reset)
			pwr_q <= 1'b0;
		else
			pwr_q <= 1'b1;
	end

	assign done = (phase == PH_DONE);
	assign rdata = rdata_q;

	// Drive the bus only for writes
	assign lcd_data = req_q.rw ? 8'hzz : req_q.data;
	assign lcd_en = (phase == PH_EN);
	assign lcd_rs = req_q.rs;
	assign lcd_rw = req_q.rw;
	assign lcd_on = pwr_q;
	assign lcd_blon = pwr_q;

endmodule

//--- char_lcd_bus/char_lcd_init_seq.sv
// LCD initialization sequencer
// Power-up wait then the fixed four-command init list
`timescale 1ns/1ps

module char_lcd_init_seq (
	input logic clk,
	input logic reset,
	input logic init_run,
	input logic cmd_sent,
	output logic cmd_valid,
	output logic [8:0] cmd,
	output logic init_done
);

	import char_lcd_pkg::*;

	logic [LCD_PWR_W-1:0] pwr_cnt;
	logic pwr_done;
	logic [LCD_STEP_W-1:0] step;
	logic cmd_pend;
	// Set after the last command, stops further requests
	logic all_sent;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pwr_cnt <= '0;
			pwr_done <= 1'b0;
			step <= '0;
			cmd_pend <= 1'b0;
			all_sent <= 1'b0;
			init_done <= 1'b0;
		end
		else
		begin
			init_done <= 1'b0;
			if (init_run && !pwr_done)
			begin
				// Panel power-up wait
				if (pwr_cnt == LCD_PWR_W'(LCD_T_POWERUP - 1))
					pwr_done <= 1'b1;
				else
					pwr_cnt <= pwr_cnt + 1'b1;
			end
			else if (cmd_pend && cmd_sent)
			begin
				cmd_pend <= 1'b0;
				if (step == LCD_STEP_W'(LCD_INIT_STEPS - 1))
				begin
					all_sent <= 1'b1;
					init_done <= 1'b1;
				end
				else
					step <= step + 1'b1;
			end
			else if (init_run && !cmd_pend && !all_sent)
				// One idle cycle between steps
				cmd_pend <= 1'b1;
		end
	end

	// Command list, bit 8 is rs
	always_comb
	begin
		case (step)
			0: cmd = {1'b0, 8'h38};
			// Display on, cursor and blink from options
			1: cmd = {1'b0, 5'b00001, 1'b1, LCD_CURSOR_ON, LCD_BLINK_ON};
			2: cmd = {1'b0, 8'h01};
			default: cmd = {1'b0, 8'h06};
		endcase
	end

	assign cmd_valid = cmd_pend;

endmodule

//--- rtl/char_lcd_ctrl.sv
// Character LCD host slave controller
// Orders initialization, busy-flag polling and host transfers
`timescale 1ns/1ps

module char_lcd_ctrl (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input char_lcd_pkg::lcd_av_req_t av_req,
	output logic [7:0] readdata,
	output logic waitrequest,
	output logic start,
	output char_lcd_pkg::lcd_bus_req_t bus_req,
	input logic done,
	input logic [7:0] rdata,
	output logic init_run,
	input logic cmd_valid,
	input logic [8:0] cmd,
	output logic cmd_sent,
	input logic init_done
);

	import char_lcd_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INIT,
		ST_START_BUSY,
		ST_CHECK_BUSY,
		ST_BEGIN_XFER,
		ST_XFER,
		ST_COMPLETE
	} state_t;

	state_t state;
	state_t state_nxt;

	// Init transfer in flight blocks reissue of a held cmd_valid
	logic xfer_act;
	logic start_q;
	lcd_bus_req_t req_q;
	lcd_rd_word_u rd_word;
	lcd_rd_word_u rd_q;

	// Panel byte seen through the status view while polling
	assign rd_word = rdata;

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				// Init has priority so a waiting access stays stalled
				if (init_run)
					state_nxt = ST_INIT;
				else if (chipselect && (av_req.read || av_req.write))
					state_nxt = ST_START_BUSY;
			end
			ST_INIT:
			begin
				if (init_done)
					state_nxt = ST_IDLE;
			end
			ST_START_BUSY:
				state_nxt = ST_CHECK_BUSY;
			ST_CHECK_BUSY:
			begin
				// Poll again while the panel is busy
				if (done && rd_word.status.busy)
					state_nxt = ST_START_BUSY;
				else if (done)
					state_nxt = ST_BEGIN_XFER;
			end
			ST_BEGIN_XFER:
				state_nxt = ST_XFER;
			ST_XFER:
			begin
				if (done)
					state_nxt = ST_COMPLETE;
			end
			ST_COMPLETE:
				state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			init_run <= 1'b1;
			xfer_act <= 1'b0;
			start_q <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			start_q <= 1'b0;
			if (init_done)
				init_run <= 1'b0;
			if (done)
				xfer_act <= 1'b0;
			// Start registered together with the request it carries
			case (state)
				ST_INIT:
				begin
					if (cmd_valid && !xfer_act)
					begin
						start_q <= 1'b1;
						xfer_act <= 1'b1;
					end
				end
				ST_START_BUSY, ST_BEGIN_XFER:
					start_q <= 1'b1;
				default:
					start_q <= 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			ST_INIT:
			begin
				if (cmd_valid && !xfer_act)
					req_q <= '{rs: cmd[8], rw: 1'b0, data: cmd[7:0]};
			end
			// Status read of the instruction register with rw high
			ST_START_BUSY:
				req_q <= '{rs: 1'b0, rw: 1'b1, data: 8'h00};
			// Host request sampled once here
			ST_BEGIN_XFER:
				req_q <= '{rs: av_req.address, rw: av_req.read, data: av_req.writedata};
			default:
				req_q <= req_q;
		endcase
		if (state == ST_XFER && done)
			rd_q <= rdata;
	end

	assign start = start_q;
	assign bus_req = req_q;
	assign cmd_sent = done && (state == ST_INIT);

	// Host sees the captured byte in the completing cycle
	assign readdata = rd_q.data;
	assign waitrequest = chipselect && (state != ST_COMPLETE);

endmodule

//--- rtl/char_lcd_top.sv
// Character LCD controller top level
// Host slave port to 8-bit HD44780 panel bus
`timescale 1ns/1ps

module char_lcd_top (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input char_lcd_pkg::lcd_av_req_t av_req,
	output logic [7:0] readdata,
	output logic waitrequest,
	inout wire [7:0] lcd_data,
	output logic lcd_en,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic lcd_on,
	output logic lcd_blon
);

	import char_lcd_pkg::*;

	// Controller to engine
	logic start;
	lcd_bus_req_t bus_req;
	logic done;
	logic [7:0] rdata;

	// Controller to sequencer
	logic init_run;
	logic cmd_valid;
	logic [8:0] cmd;
	logic cmd_sent;
	logic init_done;

	char_lcd_ctrl char_lcd_ctrl_i (
		.clk(clk),
		.reset(reset),
		.chipselect(chipselect),
		.av_req(av_req),
		.readdata(readdata),
		.waitrequest(waitrequest),
		.start(start),
		.bus_req(bus_req),
		.done(done),
		.rdata(rdata),
		.init_run(init_run),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_sent(cmd_sent),
		.init_done(init_done)
	);

	char_lcd_bus_xfer char_lcd_bus_xfer_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.bus_req(bus_req),
		.done(done),
		.rdata(rdata),
		.lcd_data(lcd_data),
		.lcd_en(lcd_en),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_on(lcd_on),
		.lcd_blon(lcd_blon)
	);

	char_lcd_init_seq char_lcd_init_seq_i (
		.clk(clk),
		.reset(reset),
		.init_run(init_run),
		.cmd_sent(cmd_sent),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.init_done(init_done)
	);

endmodule

//--- sim/lcd_panel_model.sv
// Behavioral HD44780 panel on the 8-bit bus
// Command log, display RAM, address counter and busy countdown
`timescale 1ns/1ps

module lcd_panel_model (
	inout wire [7:0] lcd_data,
	input logic lcd_en,
	input logic lcd_rs,
	input logic lcd_rw
);

	// Status reads that show busy after each write
	localparam int BUSY_READS = 3;

	logic [7:0] ram [0:127];
	logic [6:0] ac;
	logic [7:0] rd_byte;
	int busy_cnt;
	int polls;
	// Writes that reached the panel while busy was still set
	int busy_hits;
	logic [8:0] cmd_log [$];
	// Status reads seen before each write
	int poll_log [$];

	initial
	begin
		ac = '0;
		busy_cnt = 0;
		polls = 0;
		busy_hits = 0;
		for (int i = 0; i < 128; i++)
			ram[i] = 8'h20;
	end

	// Status is busy flag over address counter
	assign rd_byte = lcd_rs ? ram[ac] : {(busy_cnt != 0), ac};
	assign lcd_data = (lcd_en && lcd_rw) ? rd_byte : 8'hzz;

	// Panel latches on the falling enable edge
	always @(negedge lcd_en)
	begin
		if (lcd_rw)
		begin
			if (lcd_rs)
				ac = ac + 1'b1;
			else
			begin
				polls++;
				if (busy_cnt > 0)
					busy_cnt--;
			end
		end
		else
		begin
			if (busy_cnt != 0)
				busy_hits++;
			poll_log.push_back(polls);
			polls = 0;
			busy_cnt = BUSY_READS;
			if (lcd_rs)
			begin
				ram[ac] = lcd_data;
				ac = ac + 1'b1;
			end
			else
			begin
				cmd_log.push_back({1'b0, lcd_data});
				// Clear fills with spaces and homes the counter
				if (lcd_data == 8'h01)
				begin
					for (int i = 0; i < 128; i++)
						ram[i] = 8'h20;
					ac = '0;
				end
				else if (lcd_data[7])
					ac = lcd_data[6:0];
			end
		end
	end

endmodule

//--- sim/char_lcd_assert.sv
// Bound protocol checks on the LCD controller
// Enable setup, waitrequest release and engine start
`timescale 1ns/1ps

module char_lcd_assert (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input logic waitrequest,
	input logic start,
	input logic done,
	input logic lcd_en,
	input logic lcd_rs,
	input logic lcd_rw,
	input logic [7:0] lcd_data
);

	// Engine busy from accepted start until done
	logic eng_busy;
	// Number of failed assertions
	int fail_cnt = 0;

	always_ff @(posedge clk)
	begin
		if (reset)
			eng_busy <= 1'b0;
		else if (start && !eng_busy)
			eng_busy <= 1'b1;
		else if (done)
			eng_busy <= 1'b0;
	end

	// Control and write data settled before enable
	a_en_setup: assert property (@(posedge clk) disable iff (reset)
		$rose(lcd_en) |-> $stable({lcd_rs, lcd_rw}) && (lcd_rw || $stable(lcd_data)))
		else
		begin
			fail_cnt++;
			$error("lcd_en rose while the bus was changing");
		end

	a_wait_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(waitrequest) |-> chipselect)
		else
		begin
			fail_cnt++;
			$error("waitrequest fell without chipselect");
		end

	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> !eng_busy)
		else
		begin
			fail_cnt++;
			$error("start issued while the transfer engine was busy");
		end

endmodule

bind char_lcd_top char_lcd_assert char_lcd_assert_i (
	.clk(clk),
	.reset(reset),
	.chipselect(chipselect),
	.waitrequest(waitrequest),
	.start(start),
	.done(done),
	.lcd_en(lcd_en),
	.lcd_rs(lcd_rs),
	.lcd_rw(lcd_rw),
	.lcd_data(lcd_data)
);

//--- sim/char_lcd_tb.sv
// Character LCD controller testbench
// Directed tests against a behavioral panel
`timescale 1ns/1ps

module char_lcd_tb;

	import char_lcd_pkg::*;

	// Timeout sized from the accesses the tests make at up to five transfers each
	localparam int XFER_CYC = LCD_T_SETUP + LCD_T_EN + LCD_T_HOLD + 1;
	localparam int N_ACCESS = 25;
	localparam int N_XFERS = LCD_INIT_STEPS + 5 * N_ACCESS;
	localparam int TIMEOUT_CYC = 2 * (LCD_T_POWERUP + N_XFERS * XFER_CYC);

	logic clk;
	logic reset;
	logic chipselect;
	lcd_av_req_t av_req;
	logic [7:0] readdata;
	logic waitrequest;
	wire [7:0] lcd_data;
	logic lcd_en;
	logic lcd_rs;
	logic lcd_rw;
	logic lcd_on;
	logic lcd_blon;

	int n_checks;
	int n_errors;
	int cycle_cnt;
	int chars_since_clear;
	logic [7:0] chars [0:15];

	char_lcd_top char_lcd_top_i (
		.clk(clk),
		.reset(reset),
		.chipselect(chipselect),
		.av_req(av_req),
		.readdata(readdata),
		.waitrequest(waitrequest),
		.lcd_data(lcd_data),
		.lcd_en(lcd_en),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_on(lcd_on),
		.lcd_blon(lcd_blon)
	);

	lcd_panel_model panel_i (
		.lcd_data(lcd_data),
		.lcd_en(lcd_en),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_status(input string what, input lcd_rd_word_u got,
		input lcd_rd_word_u exp);
		n_checks++;
		if (got.status.busy !== exp.status.busy || got.status.addr_cnt !== exp.status.addr_cnt)
		begin
			n_errors++;
			$display("Error at %0t: %s is busy %b addr %0d, expected busy %b addr %0d", $time,
				what, got.status.busy, got.status.addr_cnt, exp.status.busy,
				exp.status.addr_cnt);
		end
	endtask

	task automatic check_cmd(input string what, input logic [8:0] got, input logic [8:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [7:0] pick_char();
		// Printable ASCII only
		return 8'h20 + 8'($urandom % 95);
	endfunction

	// One host access, held until waitrequest drops
	task automatic host_access(input logic addr, input logic rd, input logic [7:0] wdata,
		output logic [7:0] rdat);
		@(posedge clk);
		chipselect <= 1'b1;
		av_req <= '{address: addr, read: rd, write: !rd, writedata: wdata};
		@(negedge clk);
		while (waitrequest)
			@(negedge clk);
		rdat = readdata;
		@(posedge clk);
		chipselect <= 1'b0;
		av_req <= '0;
	endtask

	// Idle pin levels once reset has been released
	task automatic reset_outputs();
		@(posedge clk);
		@(negedge clk);
		check_byte("lcd_data after reset", lcd_data, 8'hzz);
		check_byte("Pins waitrequest en rw on blon after reset",
			{3'b000, waitrequest, lcd_en, lcd_rw, lcd_on, lcd_blon}, 8'b0000_0111);
	endtask

	task automatic init_sequence();
		logic [7:0] rd;
		lcd_rd_word_u exp;
		logic [7:0] disp_ctl;
		// Display on with cursor and blink bits from the option constants
		disp_ctl = 8'h0C | (LCD_CURSOR_ON ? 8'h02 : 8'h00) | (LCD_BLINK_ON ? 8'h01 : 8'h00);
		if (panel_i.cmd_log.size() != 0)
		begin
			n_errors++;
			$display("Init commands were sent before the first host access began");
		end
		// Status read issued while init still runs
		host_access(1'b0, 1'b1, 8'h00, rd);
		if (panel_i.cmd_log.size() != LCD_INIT_STEPS)
		begin
			n_errors++;
			$display("Host access finished with %0d init commands logged",
				panel_i.cmd_log.size());
		end
		else
		begin
			check_cmd("Init function set", panel_i.cmd_log[0], 9'h038);
			check_cmd("Init display control", panel_i.cmd_log[1], {1'b0, disp_ctl});
			check_cmd("Init clear", panel_i.cmd_log[2], 9'h001);
			check_cmd("Init entry mode", panel_i.cmd_log[3], 9'h006);
		end
		exp.status.busy = 1'b0;
		exp.status.addr_cnt = 7'd0;
		check_status("Status after init", rd, exp);
		chars_since_clear = 0;
	endtask

	task automatic char_writes();
		logic [7:0] rd;
		for (int i = 0; i < 16; i++)
		begin
			chars[i] = pick_char();
			host_access(1'b1, 1'b0, chars[i], rd);
			chars_since_clear++;
		end
		for (int i = 0; i < 16; i++)
			check_byte($sformatf("Panel RAM[%0d]", i), panel_i.ram[i], chars[i]);
	endtask

	task automatic status_read();
		logic [7:0] rd;
		lcd_rd_word_u exp;
		host_access(1'b0, 1'b1, 8'h00, rd);
		exp.status.busy = 1'b0;
		exp.status.addr_cnt = 7'(chars_since_clear);
		check_status("Status after writes", rd, exp);
	endtask

	task automatic busy_polling();
		logic [7:0] rd;
		int first;
		int hits;
		first = panel_i.poll_log.size();
		hits = panel_i.busy_hits;
		for (int i = 0; i < 4; i++)
			host_access(1'b1, 1'b0, pick_char(), rd);
		if (panel_i.poll_log.size() != first + 4)
		begin
			n_errors++;
			$display("Panel saw %0d writes, expected 4", panel_i.poll_log.size() - first);
		end
		for (int k = first; k < panel_i.poll_log.size(); k++)
		begin
			// Three busy reads per write give at least three polls
			if (panel_i.poll_log[k] < 3)
			begin
				n_errors++;
				$display("A write reached the panel after only %0d status reads",
					panel_i.poll_log[k]);
			end
		end
		if (panel_i.busy_hits != hits)
		begin
			n_errors++;
			$display("A host write reached the panel while it was busy");
		end
	endtask

	task automatic cmd_readback();
		logic [7:0] rd;
		logic [7:0] n;
		lcd_rd_word_u exp;
		n = 8'($urandom % 16);
		host_access(1'b0, 1'b0, 8'h80 | n, rd);
		check_cmd("Set address command", panel_i.cmd_log[panel_i.cmd_log.size() - 1],
			{1'b0, 8'h80 | n});
		host_access(1'b1, 1'b1, 8'h00, rd);
		check_byte($sformatf("Read back at %0d", n), rd, chars[n]);
		// Data read advances the counter
		host_access(1'b0, 1'b1, 8'h00, rd);
		exp.status.busy = 1'b0;
		exp.status.addr_cnt = 7'(n + 1);
		check_status("Status after read back", rd, exp);
	endtask

	task automatic print_counts();
		$display("Checks run %0d, errors %0d", n_checks, n_errors);
	endtask

	initial
	begin
		wait (cycle_cnt >= TIMEOUT_CYC);
		$display("Timeout after %0d cycles, a host access never completed", cycle_cnt);
		print_counts();
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		chipselect = 1'b0;
		av_req = '0;
		n_checks = 0;
		n_errors = 0;
		cycle_cnt = 0;
		chars_since_clear = 0;
		void'($urandom(32'ha05423f6));
		repeat (10)
			@(posedge clk);
		reset <= 1'b0;
		reset_outputs();
		init_sequence();
		char_writes();
		status_read();
		busy_polling();
		cmd_readback();
		repeat (5)
			@(posedge clk);
		// Protocol assertion failures count as errors
		n_errors += char_lcd_top_i.char_lcd_assert_i.fail_cnt;
		print_counts();
		if (n_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- flist.f
common/char_lcd_pkg.sv
char_lcd_bus/char_lcd_bus_xfer.sv
char_lcd_bus/char_lcd_init_seq.sv
rtl/char_lcd_ctrl.sv
rtl/char_lcd_top.sv
sim/lcd_panel_model.sv
sim/char_lcd_assert.sv
sim/char_lcd_tb.sv

//--- Bender.yml
package:
  name: char_lcd

sources:
  - common/char_lcd_pkg.sv
  - char_lcd_bus/char_lcd_bus_xfer.sv
  - char_lcd_bus/char_lcd_init_seq.sv
  - rtl/char_lcd_ctrl.sv
  - rtl/char_lcd_top.sv
  - target: test
    files:
      - sim/lcd_panel_model.sv
      - sim/char_lcd_assert.sv
      - sim/char_lcd_tb.sv
